// File: hdl/ecc_xbar_pkg.sv
package ecc_xbar_pkg;

  localparam int unsigned N_CORE     = 2;                                // Initiator ports
  localparam int unsigned N_BANK     = 4;                                // Word-interleaved banks
  localparam int unsigned BANK_SEL_W = $clog2(N_BANK);                   // Bank index width
  localparam int unsigned CORE_SEL_W = (N_CORE > 1) ? $clog2(N_CORE) : 1;
  localparam int unsigned ADDR_W     = 12;                               // Core byte address
  localparam int unsigned ROW_W      = 8;                                // Row inside one bank
  localparam int unsigned BANK_LSB   = 2;                                // Above the byte bits
  localparam int unsigned ROW_LSB    = BANK_LSB + BANK_SEL_W;            // Above the bank field
  localparam int unsigned DATA_W     = 32;
  localparam int unsigned HAM_W      = 6;                                // Hamming check bits
  localparam int unsigned PAR_W      = HAM_W + 1;                        // Plus overall parity
  localparam int unsigned CW_W       = PAR_W + DATA_W;                   // Stored codeword
  localparam int unsigned CNT_W      = 16;                               // Error counter width

  localparam logic [ADDR_W-1:0] REG_CE_CNT = 'h0;                        // Correctable count
  localparam logic [ADDR_W-1:0] REG_UE_CNT = 'h4;                        // Uncorrectable count

  // Stored word, built field by field, checked as a flat vector
  typedef union packed {
    struct packed {
      logic [PAR_W-1:0]  par;                                            // Overall parity on top
      logic [DATA_W-1:0] data;
    } f;
    logic [CW_W-1:0] raw;
  } ecc_word_u;

  // Data bit j gets the j-th column code that is not a power of two
  function automatic logic [HAM_W-1:0][DATA_W-1:0] build_chk_mask();
    logic [HAM_W-1:0][DATA_W-1:0] mask;
    int unsigned                  pos;
    mask = '0;
    pos  = 3;                                                            // First free column
    for (int unsigned j = 0; j < DATA_W; j++) begin
      while ((pos & (pos - 1)) == 0) begin
        pos++;                                                           // Skip check positions
      end
      for (int unsigned k = 0; k < HAM_W; k++) begin
        mask[k][j] = pos[k];
      end
      pos++;
    end
    return mask;
  endfunction

  localparam logic [HAM_W-1:0][DATA_W-1:0] CHK_MASK = build_chk_mask(); // Shared with decoder

  function automatic ecc_word_u secded_encode(input logic [DATA_W-1:0] data);
    ecc_word_u cw;
    cw.f.data = data;
    for (int unsigned k = 0; k < HAM_W; k++) begin
      cw.f.par[k] = ^(data & CHK_MASK[k]);                               // Even parity per group
    end
    cw.f.par[PAR_W-1] = ^{cw.f.par[HAM_W-1:0], data};                    // Whole word XORs to 0
    return cw;
  endfunction

endpackage

// File: hdl/bank_rsp_if.sv
interface bank_rsp_if;
  import ecc_xbar_pkg::*;

  logic                  valid;                                          // One-cycle pulse
  logic [CORE_SEL_W-1:0] owner;                                          // Core that issued the read
  logic [DATA_W-1:0]     data;                                           // Corrected read data
  logic                  ce;                                             // Single-bit error fixed
  logic                  ue;                                             // Double-bit error seen

  modport dec (
    output valid, owner, data, ce, ue
  );

  modport sink (
    input valid, owner, data, ce, ue
  );

endinterface

// File: hdl/bank_arbiter.sv
module bank_arbiter #(
  parameter int unsigned BANK_IDX = 0                                    // Bank served here
) (
  input  logic                                                     clk_i,
  input  logic                                                     rst_ni,
  input  logic [ecc_xbar_pkg::N_CORE-1:0]                          core_req_i,
  input  logic [ecc_xbar_pkg::N_CORE-1:0]                          core_we_i,
  input  logic [ecc_xbar_pkg::N_CORE-1:0][ecc_xbar_pkg::ADDR_W-1:0] core_addr_i,
  input  logic [ecc_xbar_pkg::N_CORE-1:0][ecc_xbar_pkg::DATA_W-1:0] core_wdata_i,
  output logic [ecc_xbar_pkg::N_CORE-1:0]                          gnt_o,
  output logic                                                     mem_req_o,
  output logic                                                     mem_we_o,
  output logic [ecc_xbar_pkg::ROW_W-1:0]                           mem_row_o,
  output logic [ecc_xbar_pkg::CW_W-1:0]                            mem_wdata_o,
  output logic                                                     rd_pending_o,
  output logic [ecc_xbar_pkg::CORE_SEL_W-1:0]                      rd_owner_o
);
  import ecc_xbar_pkg::*;

  localparam logic [BANK_SEL_W-1:0] BANK_ID = BANK_SEL_W'(BANK_IDX);

  logic [N_CORE-1:0]     hit;                                            // Requests aimed here
  logic                  win_found;
  logic [CORE_SEL_W-1:0] win_idx;
  logic [CORE_SEL_W-1:0] last_q;                                         // Previous winner
  logic                  rd_pending_q;
  logic [CORE_SEL_W-1:0] rd_owner_q;
  ecc_word_u             enc_word;

  always_comb begin
    for (int unsigned c = 0; c < N_CORE; c++) begin
      hit[c] = core_req_i[c] &&
               (core_addr_i[c][BANK_LSB +: BANK_SEL_W] == BANK_ID);      // Interleave by word
    end
  end

  // Search starts just after the last winner
  always_comb begin
    int unsigned cand;
    win_found = 1'b0;
    win_idx   = last_q;
    for (int unsigned off = 1; off <= N_CORE; off++) begin
      cand = (int'(last_q) + off) % N_CORE;
      if (!win_found && hit[cand]) begin
        win_found = 1'b1;
        win_idx   = CORE_SEL_W'(cand);
      end
    end
  end

  always_comb begin
    for (int unsigned c = 0; c < N_CORE; c++) begin
      gnt_o[c] = win_found && (win_idx == CORE_SEL_W'(c));               // Same-cycle grant
    end
  end

  assign enc_word    = secded_encode(core_wdata_i[win_idx]);             // Encode on the way in
  assign mem_req_o   = win_found;
  assign mem_we_o    = core_we_i[win_idx];
  assign mem_row_o   = core_addr_i[win_idx][ROW_LSB +: ROW_W];
  assign mem_wdata_o = enc_word.raw;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      last_q       <= '0;
      rd_pending_q <= 1'b0;
      rd_owner_q   <= '0;
    end else begin
      rd_pending_q <= win_found && !core_we_i[win_idx];                  // Data back next cycle
      if (win_found) begin
        last_q     <= win_idx;                                           // Rotate priority
        rd_owner_q <= win_idx;
      end
    end
  end

  assign rd_pending_o = rd_pending_q;
  assign rd_owner_o   = rd_owner_q;

endmodule

// File: hdl/secded_decoder.sv
module secded_decoder (
  input  logic                                rd_pending_i,
  input  logic [ecc_xbar_pkg::CORE_SEL_W-1:0] rd_owner_i,
  input  logic [ecc_xbar_pkg::CW_W-1:0]       mem_rdata_i,
  bank_rsp_if.dec                             rsp
);
  import ecc_xbar_pkg::*;

  ecc_word_u         cw;                                                 // Word read from memory
  logic [HAM_W-1:0]  syndrome;
  logic              par_err;                                            // Odd number of flips
  logic              syn_nz;
  logic [DATA_W-1:0] flip;                                               // Bit to correct
  logic [DATA_W-1:0] data_fix;

  assign cw.raw = mem_rdata_i;

  always_comb begin
    for (int unsigned k = 0; k < HAM_W; k++) begin
      syndrome[k] = cw.f.par[k] ^ (^(cw.f.data & CHK_MASK[k]));          // Recompute each group
    end
  end

  assign par_err = ^cw.raw;                                              // Zero for a clean word
  assign syn_nz  = |syndrome;

  // Syndrome equal to a data column points at that data bit
  always_comb begin
    logic [HAM_W-1:0] col;
    for (int unsigned j = 0; j < DATA_W; j++) begin
      for (int unsigned k = 0; k < HAM_W; k++) begin
        col[k] = CHK_MASK[k][j];
      end
      flip[j] = par_err && (syndrome == col);
    end
  end

  // Check-bit or parity-bit hits leave data untouched
  assign data_fix = cw.f.data ^ flip;

  assign rsp.valid = rd_pending_i;                                       // Cycle after the grant
  assign rsp.owner = rd_owner_i;
  assign rsp.data  = data_fix;
  assign rsp.ce    = rd_pending_i && par_err;                            // Single flip, fixed
  assign rsp.ue    = rd_pending_i && syn_nz && !par_err;                 // Even flips, not fixable

endmodule

// File: hdl/response_router.sv
module response_router (
  bank_rsp_if.sink                                                  rsp [ecc_xbar_pkg::N_BANK],
  output logic [ecc_xbar_pkg::N_CORE-1:0]                           core_rvalid_o,
  output logic [ecc_xbar_pkg::N_CORE-1:0][ecc_xbar_pkg::DATA_W-1:0] core_rdata_o,
  output logic [ecc_xbar_pkg::N_CORE-1:0]                           core_rerr_o
);
  import ecc_xbar_pkg::*;

  logic [N_BANK-1:0]                 valid_v;
  logic [N_BANK-1:0][CORE_SEL_W-1:0] owner_v;
  logic [N_BANK-1:0][DATA_W-1:0]     data_v;
  logic [N_BANK-1:0]                 ue_v;

  // Per-bank responses as flat vectors
  for (genvar b = 0; b < N_BANK; b++) begin : gen_unpack
    assign valid_v[b] = rsp[b].valid;
    assign owner_v[b] = rsp[b].owner;
    assign data_v[b]  = rsp[b].data;
    assign ue_v[b]    = rsp[b].ue;
  end

  // One granted request per core, so one bank at most matches
  always_comb begin
    core_rvalid_o = '0;
    core_rdata_o  = '0;
    core_rerr_o   = '0;
    for (int unsigned c = 0; c < N_CORE; c++) begin
      for (int unsigned b = 0; b < N_BANK; b++) begin
        if (valid_v[b] && (owner_v[b] == CORE_SEL_W'(c))) begin
          core_rvalid_o[c] = 1'b1;
          core_rdata_o[c]  = data_v[b];
          core_rerr_o[c]   = ue_v[b];                                    // Only uncorrectable
        end
      end
    end
  end

endmodule

// File: hdl/ecc_err_regs.sv
module ecc_err_regs (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  bank_rsp_if.sink                        rsp [ecc_xbar_pkg::N_BANK],
  input  logic                            reg_req_i,
  input  logic                            reg_we_i,
  input  logic [ecc_xbar_pkg::ADDR_W-1:0] reg_addr_i,
  input  logic [ecc_xbar_pkg::DATA_W-1:0] reg_wdata_i,
  output logic                            reg_gnt_o,
  output logic                            reg_rvalid_o,
  output logic [ecc_xbar_pkg::DATA_W-1:0] reg_rdata_o
);
  import ecc_xbar_pkg::*;

  localparam int unsigned INC_W = $clog2(N_BANK + 1);                    // Up to all banks at once

  logic [N_BANK-1:0] ce_v;
  logic [N_BANK-1:0] ue_v;
  logic [INC_W-1:0]  ce_inc;
  logic [INC_W-1:0]  ue_inc;
  logic [CNT_W-1:0]  ce_cnt_q;
  logic [CNT_W-1:0]  ue_cnt_q;
  logic              wr_en;
  logic              rd_en;
  logic [DATA_W-1:0] rdata_d;
  logic              rvalid_q;
  logic [DATA_W-1:0] rdata_q;

  function automatic logic [CNT_W-1:0] sat_add(input logic [CNT_W-1:0] cnt,
                                               input logic [INC_W-1:0] inc);
    logic [CNT_W:0] sum;
    sum = {1'b0, cnt} + (CNT_W + 1)'(inc);
    return sum[CNT_W] ? '1 : sum[CNT_W-1:0];                             // Stick at all ones
  endfunction

  for (genvar b = 0; b < N_BANK; b++) begin : gen_flags
    assign ce_v[b] = rsp[b].ce;
    assign ue_v[b] = rsp[b].ue;
  end

  always_comb begin
    ce_inc = '0;
    ue_inc = '0;
    for (int unsigned b = 0; b < N_BANK; b++) begin
      ce_inc += INC_W'(ce_v[b]);                                         // Banks flagging this cycle
      ue_inc += INC_W'(ue_v[b]);
    end
  end

  assign reg_gnt_o = reg_req_i;                                          // Never stalls
  assign wr_en     = reg_req_i && reg_we_i;                              // Write data is ignored
  assign rd_en     = reg_req_i && !reg_we_i;

  always_comb begin
    case (reg_addr_i)
      REG_CE_CNT: rdata_d = DATA_W'(ce_cnt_q);
      REG_UE_CNT: rdata_d = DATA_W'(ue_cnt_q);
      default:    rdata_d = '0;                                          // Unmapped reads as zero
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ce_cnt_q <= '0;
      ue_cnt_q <= '0;
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= rd_en;
      ce_cnt_q <= (wr_en && reg_addr_i == REG_CE_CNT) ? '0 : sat_add(ce_cnt_q, ce_inc);
      ue_cnt_q <= (wr_en && reg_addr_i == REG_UE_CNT) ? '0 : sat_add(ue_cnt_q, ue_inc);
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      rdata_q <= rdata_d;                                                // Sampled at request
    end
  end

  assign reg_rvalid_o = rvalid_q;
  assign reg_rdata_o  = rdata_q;

endmodule

// File: hdl/ecc_xbar.sv
module ecc_xbar (
  input  logic                                                      clk_i,
  input  logic                                                      rst_ni,
  input  logic [ecc_xbar_pkg::N_CORE-1:0]                           core_req_i,
  input  logic [ecc_xbar_pkg::N_CORE-1:0]                           core_we_i,
  input  logic [ecc_xbar_pkg::N_CORE-1:0][ecc_xbar_pkg::ADDR_W-1:0] core_addr_i,
  input  logic [ecc_xbar_pkg::N_CORE-1:0][ecc_xbar_pkg::DATA_W-1:0] core_wdata_i,
  output logic [ecc_xbar_pkg::N_CORE-1:0]                           core_gnt_o,
  output logic [ecc_xbar_pkg::N_CORE-1:0]                           core_rvalid_o,
  output logic [ecc_xbar_pkg::N_CORE-1:0][ecc_xbar_pkg::DATA_W-1:0] core_rdata_o,
  output logic [ecc_xbar_pkg::N_CORE-1:0]                           core_rerr_o,
  output logic [ecc_xbar_pkg::N_BANK-1:0]                           mem_req_o,
  output logic [ecc_xbar_pkg::N_BANK-1:0]                           mem_we_o,
  output logic [ecc_xbar_pkg::N_BANK-1:0][ecc_xbar_pkg::ROW_W-1:0]  mem_row_o,
  output logic [ecc_xbar_pkg::N_BANK-1:0][ecc_xbar_pkg::CW_W-1:0]   mem_wdata_o,
  input  logic [ecc_xbar_pkg::N_BANK-1:0][ecc_xbar_pkg::CW_W-1:0]   mem_rdata_i,
  input  logic                                                      reg_req_i,
  input  logic                                                      reg_we_i,
  input  logic [ecc_xbar_pkg::ADDR_W-1:0]                           reg_addr_i,
  input  logic [ecc_xbar_pkg::DATA_W-1:0]                           reg_wdata_i,
  output logic                                                      reg_gnt_o,
  output logic                                                      reg_rvalid_o,
  output logic [ecc_xbar_pkg::DATA_W-1:0]                           reg_rdata_o
);
  import ecc_xbar_pkg::*;

  logic [N_BANK-1:0][N_CORE-1:0]     bank_gnt;                           // Grants seen per bank
  logic [N_BANK-1:0]                 rd_pending;
  logic [N_BANK-1:0][CORE_SEL_W-1:0] rd_owner;

  bank_rsp_if rsp_if [N_BANK] ();                                        // Decoded responses

  for (genvar b = 0; b < N_BANK; b++) begin : gen_bank
    bank_arbiter #(
      .BANK_IDX     ( b               )
    ) bank_arbiter_inst (
      .clk_i        ( clk_i           ),
      .rst_ni       ( rst_ni          ),
      .core_req_i   ( core_req_i      ),
      .core_we_i    ( core_we_i       ),
      .core_addr_i  ( core_addr_i     ),
      .core_wdata_i ( core_wdata_i    ),
      .gnt_o        ( bank_gnt[b]     ),
      .mem_req_o    ( mem_req_o[b]    ),
      .mem_we_o     ( mem_we_o[b]     ),
      .mem_row_o    ( mem_row_o[b]    ),
      .mem_wdata_o  ( mem_wdata_o[b]  ),
      .rd_pending_o ( rd_pending[b]   ),
      .rd_owner_o   ( rd_owner[b]     )
    );

    secded_decoder secded_decoder_inst (
      .rd_pending_i ( rd_pending[b]   ),
      .rd_owner_i   ( rd_owner[b]     ),
      .mem_rdata_i  ( mem_rdata_i[b]  ),
      .rsp          ( rsp_if[b]       )
    );
  end

  // A core wins in at most one bank, the one its address selects
  always_comb begin
    core_gnt_o = '0;
    for (int unsigned b = 0; b < N_BANK; b++) begin
      core_gnt_o |= bank_gnt[b];
    end
  end

  response_router response_router_inst (
    .rsp           ( rsp_if        ),
    .core_rvalid_o ( core_rvalid_o ),
    .core_rdata_o  ( core_rdata_o  ),
    .core_rerr_o   ( core_rerr_o   )
  );

  ecc_err_regs ecc_err_regs_inst (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .rsp          ( rsp_if       ),
    .reg_req_i    ( reg_req_i    ),
    .reg_we_i     ( reg_we_i     ),
    .reg_addr_i   ( reg_addr_i   ),
    .reg_wdata_i  ( reg_wdata_i  ),
    .reg_gnt_o    ( reg_gnt_o    ),
    .reg_rvalid_o ( reg_rvalid_o ),
    .reg_rdata_o  ( reg_rdata_o  )
  );

endmodule

// File: sim/tb_ecc_xbar.sv
module tb_ecc_xbar;
  timeunit 1ns;
  timeprecision 100ps;
  import ecc_xbar_pkg::*;

  localparam int          TIMEOUT   = 64;                                // Cycles per wait
  localparam logic [31:0] LFSR_SEED = 32'h2429442d;
  localparam logic [31:0] LFSR_TAPS = 32'h80200003;                      // x^32+x^22+x^2+x+1

  logic                             clk_i;
  logic                             rst_ni;
  logic [N_CORE-1:0]                core_req_i;
  logic [N_CORE-1:0]                core_we_i;
  logic [N_CORE-1:0][ADDR_W-1:0]    core_addr_i;
  logic [N_CORE-1:0][DATA_W-1:0]    core_wdata_i;
  logic [N_CORE-1:0]                core_gnt_o;
  logic [N_CORE-1:0]                core_rvalid_o;
  logic [N_CORE-1:0][DATA_W-1:0]    core_rdata_o;
  logic [N_CORE-1:0]                core_rerr_o;
  logic [N_BANK-1:0]                mem_req_o;
  logic [N_BANK-1:0]                mem_we_o;
  logic [N_BANK-1:0][ROW_W-1:0]     mem_row_o;
  logic [N_BANK-1:0][CW_W-1:0]      mem_wdata_o;
  logic [N_BANK-1:0][CW_W-1:0]      mem_rdata_i;
  logic                             reg_req_i;
  logic                             reg_we_i;
  logic [ADDR_W-1:0]                reg_addr_i;
  logic [DATA_W-1:0]                reg_wdata_i;
  logic                             reg_gnt_o;
  logic                             reg_rvalid_o;
  logic [DATA_W-1:0]                reg_rdata_o;

  logic [CW_W-1:0]   mem      [N_BANK][2**ROW_W];                        // Stored codewords
  logic [CW_W-1:0]   flip_mem [N_BANK][2**ROW_W];                        // Injected bit flips
  logic [DATA_W-1:0] shadow   [2**(ADDR_W-2)];                           // Last data written per word
  logic [31:0]       lfsr_q;
  int                ce_seen;                                            // Single-flip reads
  int                ue_seen;                                            // Double-flip reads

  ecc_xbar ecc_xbar_inst (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // Bank memories, one-cycle read latency
  initial begin
    mem_rdata_i <= '0;
    forever begin
      @(posedge clk_i);
      for (int b = 0; b < N_BANK; b++) begin
        if (mem_req_o[b] && mem_we_o[b]) begin
          mem[b][mem_row_o[b]] <= mem_wdata_o[b];
        end else if (mem_req_o[b]) begin
          mem_rdata_i[b] <= mem[b][mem_row_o[b]] ^ flip_mem[b][mem_row_o[b]];
        end
      end
    end
  end

  function automatic logic rand_bit();
    logic b;
    b      = lfsr_q[0];
    lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ LFSR_TAPS) : (lfsr_q >> 1);
    return b;
  endfunction

  task automatic stop_run(input string what);
    $display("** FAIL **");
    $display("%s", what);
    $fatal(1);
  endtask

  task automatic check_data(input string name, input logic [DATA_W-1:0] exp_v,
                            input logic [DATA_W-1:0] act_v);
    if (act_v !== exp_v) begin
      stop_run($sformatf("mismatch %s expected %h actual %h", name, exp_v, act_v));
    end
  endtask

  task automatic check_err(input string name, input logic exp_v, input logic act_v);
    if (act_v !== exp_v) begin
      stop_run($sformatf("mismatch %s expected %b actual %b", name, exp_v, act_v));
    end
  endtask

  task automatic check_cnt(input string name, input logic [CNT_W-1:0] exp_v,
                           input logic [CNT_W-1:0] act_v);
    if (act_v !== exp_v) begin
      stop_run($sformatf("mismatch %s expected %0d actual %0d", name, exp_v, act_v));
    end
  endtask

  // Holds each request until granted, collects reads one cycle after grant
  task automatic access(input logic [N_CORE-1:0] want, input logic [N_CORE-1:0] we,
                        input logic [N_CORE-1:0][ADDR_W-1:0] addrs,
                        input logic [N_CORE-1:0][DATA_W-1:0] wdata,
                        output logic [N_CORE-1:0][DATA_W-1:0] rdata,
                        output logic [N_CORE-1:0] rerr, output logic [N_CORE-1:0] first);
    logic [N_CORE-1:0] pend;
    logic [N_CORE-1:0] wait_rv;
    int                cycles;
    rdata   = '0;
    rerr    = '0;
    first   = '0;
    pend    = want;
    wait_rv = '0;
    cycles  = 0;
    @(posedge clk_i);
    core_req_i   <= want;
    core_we_i    <= we;
    core_addr_i  <= addrs;
    core_wdata_i <= wdata;
    while (pend != '0 || wait_rv != '0) begin
      @(negedge clk_i);
      for (int c = 0; c < N_CORE; c++) begin
        if (wait_rv[c] && !core_rvalid_o[c]) begin
          stop_run($sformatf("core %0d read got no rvalid one cycle after grant", c));
        end else if (wait_rv[c]) begin
          rdata[c]   = core_rdata_o[c];
          rerr[c]    = core_rerr_o[c];
          wait_rv[c] = 1'b0;
        end else if (core_rvalid_o[c]) begin
          stop_run($sformatf("core %0d got rvalid with no read outstanding", c));
        end
        if (pend[c] && core_gnt_o[c]) begin
          pend[c]    = 1'b0;
          wait_rv[c] = !we[c];                                           // Writes get no response
          first[c]   = (cycles == 0);
        end
      end
      cycles++;
      if (cycles > TIMEOUT) begin
        stop_run("core request was not granted before the timeout");
      end
      @(posedge clk_i);
      core_req_i <= pend;
    end
  endtask

  task automatic reg_access(input logic we, input logic [ADDR_W-1:0] addr,
                            output logic [DATA_W-1:0] rdata);
    int cycles;
    rdata  = '0;
    cycles = 0;
    @(posedge clk_i);
    reg_req_i  <= 1'b1;
    reg_we_i   <= we;
    reg_addr_i <= addr;
    do begin
      @(negedge clk_i);
      cycles++;
      if (cycles > TIMEOUT) begin
        stop_run("register port was not granted before the timeout");
      end
    end while (!reg_gnt_o);
    @(posedge clk_i);
    reg_req_i <= 1'b0;
    if (we) begin
      @(negedge clk_i);
      if (reg_rvalid_o) begin
        stop_run("register write was answered with rvalid");
      end
    end else begin
      cycles = 0;
      while (!reg_rvalid_o) begin                                        // Read data comes next cycle
        @(negedge clk_i);
        cycles++;
        if (cycles > TIMEOUT) begin
          stop_run("register read returned no rvalid before the timeout");
        end
      end
      rdata = reg_rdata_o;
    end
  endtask

  task automatic write_word(input int core, input logic [ADDR_W-1:0] addr,
                            input logic [DATA_W-1:0] data, input string name);
    logic [N_CORE-1:0]             want;
    logic [N_CORE-1:0][ADDR_W-1:0] addrs;
    logic [N_CORE-1:0][DATA_W-1:0] wdata;
    logic [N_CORE-1:0][DATA_W-1:0] rdata;
    logic [N_CORE-1:0]             rerr;
    logic [N_CORE-1:0]             first;
    ecc_word_u                     word;
    want        = '0;
    want[core]  = 1'b1;
    addrs       = '0;
    addrs[core] = addr;
    wdata       = '0;
    wdata[core] = data;
    access(want, want, addrs, wdata, rdata, rerr, first);
    shadow[addr[ADDR_W-1:2]] = data;
    @(negedge clk_i);
    word.raw = mem[addr[BANK_LSB +: BANK_SEL_W]][addr[ROW_LSB +: ROW_W]];
    check_data({name, "_stored"}, data, word.f.data);                    // Data field kept as is
  endtask

  task automatic read_word(input int core, input logic [ADDR_W-1:0] addr,
                           input logic [CW_W-1:0] flip, input logic [DATA_W-1:0] exp_v,
                           input string name);
    logic [N_CORE-1:0]             want;
    logic [N_CORE-1:0][ADDR_W-1:0] addrs;
    logic [N_CORE-1:0][DATA_W-1:0] rdata;
    logic [N_CORE-1:0]             rerr;
    logic [N_CORE-1:0]             first;
    int                            nflip;
    nflip       = $countones(flip);
    want        = '0;
    want[core]  = 1'b1;
    addrs       = '0;
    addrs[core] = addr;
    @(negedge clk_i);
    flip_mem[addr[BANK_LSB +: BANK_SEL_W]][addr[ROW_LSB +: ROW_W]] = flip;
    access(want, '0, addrs, '0, rdata, rerr, first);
    flip_mem[addr[BANK_LSB +: BANK_SEL_W]][addr[ROW_LSB +: ROW_W]] = '0;
    if (nflip < 2) begin
      check_data({name, "_rdata"}, exp_v, rdata[core]);                  // Clean or corrected
    end
    check_err({name, "_rerr"}, nflip == 2, rerr[core]);
    if (nflip == 1) begin
      ce_seen++;
    end else if (nflip == 2) begin
      ue_seen++;
    end
  endtask

  // Random request patterns from both cores at once
  task automatic pair_reads(input logic [ADDR_W-1:0] a0, input logic [ADDR_W-1:0] a1,
                            input int rounds, input string name);
    logic [N_CORE-1:0]             want;
    logic [N_CORE-1:0][ADDR_W-1:0] addrs;
    logic [N_CORE-1:0][DATA_W-1:0] rdata;
    logic [N_CORE-1:0]             rerr;
    logic [N_CORE-1:0]             first;
    logic                          same_bank;
    addrs[0]  = a0;
    addrs[1]  = a1;
    same_bank = (a0[BANK_LSB +: BANK_SEL_W] == a1[BANK_LSB +: BANK_SEL_W]);
    for (int r = 0; r < rounds; r++) begin
      for (int c = 0; c < N_CORE; c++) begin
        want[c] = rand_bit();
      end
      if (want != '0) begin
        access(want, '0, addrs, '0, rdata, rerr, first);
        for (int c = 0; c < N_CORE; c++) begin
          if (want[c]) begin
            check_data($sformatf("%s_r%0d_c%0d", name, r, c), shadow[addrs[c][ADDR_W-1:2]],
                       rdata[c]);
            check_err($sformatf("%s_r%0d_c%0d_rerr", name, r, c), 1'b0, rerr[c]);
          end
        end
        if (&want && same_bank) begin
          check_err($sformatf("%s_r%0d_one_gnt", name, r), 1'b0, &first);  // One winner per bank
        end else if (&want) begin
          check_err($sformatf("%s_r%0d_both_gnt", name, r), 1'b1, &first);
        end
      end
    end
  endtask

  task automatic check_counter(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] exp_v,
                               input string name);
    logic [DATA_W-1:0] rdata;
    logic [CNT_W-1:0]  seen;
    repeat (2) @(posedge clk_i);                                         // Let the last update land
    reg_access(1'b0, addr, rdata);
    seen = (addr == REG_CE_CNT) ? CNT_W'(ce_seen) : CNT_W'(ue_seen);
    check_cnt({name, "_cnt"}, exp_v[CNT_W-1:0], rdata[CNT_W-1:0]);
    check_cnt({name, "_flips"}, seen, rdata[CNT_W-1:0]);
  endtask

  task automatic clear_counter(input logic [ADDR_W-1:0] addr);
    logic [DATA_W-1:0] rdata;
    reg_access(1'b1, addr, rdata);
    if (addr == REG_CE_CNT) begin
      ce_seen = 0;
    end else begin
      ue_seen = 0;
    end
  endtask

  initial begin
    int                fd;
    int                code;
    int                nitems;
    int                lineno;
    int                op;
    int                core;
    string             line;
    string             name;
    logic [ADDR_W-1:0] addr_f;
    logic [DATA_W-1:0] data_f;
    logic [CW_W-1:0]   flip_f;
    logic [DATA_W-1:0] exp_f;
    rst_ni       <= 1'b0;
    core_req_i   <= '0;
    core_we_i    <= '0;
    core_addr_i  <= '0;
    core_wdata_i <= '0;
    reg_req_i    <= 1'b0;
    reg_we_i     <= 1'b0;
    reg_addr_i   <= '0;
    reg_wdata_i  <= '0;
    lfsr_q  = LFSR_SEED;
    ce_seen = 0;
    ue_seen = 0;
    for (int b = 0; b < N_BANK; b++) begin
      for (int r = 0; r < 2**ROW_W; r++) begin
        flip_mem[b][r] = '0;
      end
    end
    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    check_err("reset_gnt", 1'b0, |core_gnt_o);
    check_err("reset_rvalid", 1'b0, |core_rvalid_o);
    check_err("reset_mem_req", 1'b0, |mem_req_o);
    check_err("reset_reg_rvalid", 1'b0, reg_rvalid_o);
    fd = $fopen("sim/ecc_xbar_testdata.txt", "r");
    if (fd == 0) begin
      stop_run("could not open sim/ecc_xbar_testdata.txt");
    end
    lineno = 0;
    while (!$feof(fd)) begin
      code = $fgets(line, fd);
      lineno++;
      if (code > 0 && line.len() > 1 && line.getc(0) != "#") begin
        name   = $sformatf("line%0d", lineno);
        nitems = $sscanf(line, "%h %h %h %h %h %h", op, core, addr_f, data_f, flip_f, exp_f);
        if (nitems != 6) begin
          stop_run($sformatf("line %0d of the test data has missing columns", lineno));
        end else begin
          case (op)
            0:       write_word(core, addr_f, data_f, name);
            1:       read_word(core, addr_f, flip_f, exp_f, name);
            2:       check_counter(addr_f, exp_f, name);
            3:       clear_counter(addr_f);
            4:       pair_reads(addr_f, data_f[ADDR_W-1:0], int'(flip_f[15:0]), name);
            default: stop_run($sformatf("line %0d has an unknown operation", lineno));
          endcase
        end
      end
    end
    $fclose(fd);
    $display("** PASS **");
    $finish;
  end

endmodule

// File: ecc_xbar.f
hdl/ecc_xbar_pkg.sv
hdl/bank_rsp_if.sv
hdl/bank_arbiter.sv
hdl/secded_decoder.sv
hdl/response_router.sv
hdl/ecc_err_regs.sv
hdl/ecc_xbar.sv
sim/tb_ecc_xbar.sv

// File: Makefile
VERILATOR := verilator
TOP       := tb_ecc_xbar
FILELIST  := ecc_xbar.f
BUILD_DIR := obj_dir
VFLAGS    := --binary --timing -j 0
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# A $fatal in the testbench gives a nonzero exit status
run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)

// File: sim/ecc_xbar_testdata.txt
# op core addr data flip exp, all hex; op 0 write, 1 read with flip xored into the stored word
# op 2 counter read (exp is the count), 3 counter clear, 4 paired reads (data is core 1 addr)
2 0 000 00000000 0000000000 00000000
2 0 004 00000000 0000000000 00000000
# Fill one row in every bank from both cores
0 0 010 deadbeef 0000000000 00000000
0 1 014 12345678 0000000000 00000000
0 0 020 a5a5a5a5 0000000000 00000000
0 1 028 0badf00d 0000000000 00000000
0 0 3fc ffffffff 0000000000 00000000
0 1 ff0 00000001 0000000000 00000000
0 1 03c 5a5a0ff0 0000000000 00000000
# Clean reads, some from the other core
1 0 010 00000000 0000000000 deadbeef
1 1 010 00000000 0000000000 deadbeef
1 1 014 00000000 0000000000 12345678
1 0 028 00000000 0000000000 0badf00d
1 1 3fc 00000000 0000000000 ffffffff
1 0 ff0 00000000 0000000000 00000001
1 0 03c 00000000 0000000000 5a5a0ff0
# Single flips on data bit 0, data bit 31, check bit 0 and the overall parity bit
1 0 010 00000000 0000000001 deadbeef
1 1 014 00000000 0080000000 12345678
1 0 020 00000000 0100000000 a5a5a5a5
1 1 028 00000000 4000000000 0badf00d
# Double flips on two data bits and on a check bit plus a data bit
1 0 3fc 00000000 0000000021 00000000
1 1 ff0 00000000 2000000008 00000000
2 0 000 00000000 0000000000 00000004
2 0 004 00000000 0000000000 00000002
3 0 000 00000000 0000000000 00000000
2 0 000 00000000 0000000000 00000000
2 0 004 00000000 0000000000 00000002
3 0 004 00000000 0000000000 00000000
2 0 004 00000000 0000000000 00000000
# Both cores on one bank, on two banks, then on one word; flip column is the round count
4 0 010 00000020 0000000010 00000000
4 0 014 00000028 0000000010 00000000
4 0 3fc 00000ff0 0000000010 00000000
4 0 010 00000010 0000000010 00000000
# Overwrite, then fresh errors after the clears
0 1 010 cafef00d 0000000000 00000000
1 0 010 00000000 0000000000 cafef00d
4 0 010 00000014 0000000008 00000000
1 1 014 00000000 0000000400 12345678
1 0 020 00000000 0000000003 00000000
2 0 000 00000000 0000000000 00000001
2 0 004 00000000 0000000000 00000001
